// ==== irda_pkg.sv ====
package irda_pkg;

	// fast divider
	localparam int cdr_width = 24;
	localparam logic [cdr_width-1:0] mult = 24'd100000;	// fixed-point scale of f_cdr
	localparam int bus_clock_mhz = 200;

	// 40 MHz equivalent strobe out of reset
	localparam logic [cdr_width-1:0] reset_cdr = cdr_width'((bus_clock_mhz / 40) * mult);

	// tick dividers, reload n gives one pulse per n+1 strobes
	localparam int tick_width = 4;
	localparam logic [tick_width-1:0] mir_full_reload = 4'd3;	// 4 strobes per bit
	localparam logic [tick_width-1:0] mir_half_reload = 4'd7;	// 8 strobes per bit
	localparam logic [tick_width-1:0] fir8_reload = 4'd4;
	localparam logic [tick_width-1:0] fir4_reload = 4'd9;
	localparam logic [tick_width-1:0] mir_rst_count = 4'd1;

	// requested operating mode
	typedef enum logic [1:0] {
		mode_off,
		mode_mir_full,
		mode_mir_half,
		mode_fir
	} irda_mode_e;

	// serializer payloads
	typedef logic [7:0] mir_byte_t;	// one MIR byte
	typedef logic [3:0] fir_chip_t;	// one FIR chip group

endpackage

// ==== irda_frac_div.sv ====
module irda_frac_div (
	input  logic                           clk,
	input  logic                           wb_rst_i,
	input  logic [irda_pkg::cdr_width-1:0] f_cdr_i,
	input  logic                           en_reload_i,
	output logic                           fast_enable_o
);

	// local divisor, counts down by mult per clock
	logic [irda_pkg::cdr_width-1:0] l_cdr;

	// the remainder below mult is carried into the next period,
	// so a non-integer f_cdr/mult averages out over many strobes
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			fast_enable_o <= 1'b0;
			l_cdr <= irda_pkg::reset_cdr;
		end else if (en_reload_i) begin
			fast_enable_o <= 1'b0;	// restart the count
			l_cdr <= f_cdr_i;
		end else if (l_cdr > irda_pkg::mult) begin
			fast_enable_o <= 1'b0;
			l_cdr <= l_cdr - irda_pkg::mult;
		end else begin
			fast_enable_o <= 1'b1;
			l_cdr <= l_cdr + f_cdr_i - irda_pkg::mult;	// carry fraction forward
		end
	end

endmodule

// ==== irda_tick_div.sv ====
module irda_tick_div #(
	parameter logic [irda_pkg::tick_width-1:0] rst_count = '0
) (
	input  logic                            clk,
	input  logic                            wb_rst_i,
	input  logic                            strobe_i,
	input  logic                            gate_i,
	input  logic [irda_pkg::tick_width-1:0] reload_i,
	output logic                            enable_o
);

	logic [irda_pkg::tick_width-1:0] count;

	// count only moves on a gated strobe
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			count <= rst_count;
			enable_o <= 1'b0;
		end else if (strobe_i && gate_i) begin
			if (count == '0) begin
				enable_o <= 1'b1;
				count <= reload_i;	// reload_i may change between periods
			end else begin
				enable_o <= 1'b0;
				count <= count - 1'b1;
			end
		end else begin
			enable_o <= 1'b0;	// hold count while gated off
		end
	end

endmodule

// ==== irda_fast_enable_gen.sv ====
module irda_fast_enable_gen (
	input  logic                           clk,
	input  logic                           wb_rst_i,
	input  logic                           tx_select_i,
	input  logic                           loopback_enable_i,
	input  logic                           mir_mode_i,
	input  logic                           mir_half_i,
	input  logic                           fir_mode_i,
	input  logic [irda_pkg::cdr_width-1:0] f_cdr_i,
	input  logic                           en_reload_i,
	output logic                           fast_enable_o,
	output logic                           mir_txbit_enable_o,
	output logic                           mir_rxbit_enable_o,
	output logic                           fir_tx8_enable_o,
	output logic                           fir_tx4_enable_o,
	output logic                           fir_rx8_enable_o,
	output logic                           fir_rx4_enable_o
);

	logic                            fast_tx_enable;
	logic                            fast_rx_enable;
	logic [irda_pkg::tick_width-1:0] mir_reload;

	irda_frac_div irda_frac_div_i (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.f_cdr_i       (f_cdr_i),
		.en_reload_i   (en_reload_i),
		.fast_enable_o (fast_enable_o)
	);

	// loopback drives both directions
	assign fast_tx_enable = fast_enable_o & (loopback_enable_i | tx_select_i);
	assign fast_rx_enable = fast_enable_o & (loopback_enable_i | ~tx_select_i);

	// half rate is the default when MIR is off
	assign mir_reload = (mir_mode_i && !mir_half_i) ? irda_pkg::mir_full_reload
		: irda_pkg::mir_half_reload;

	// separate tx and rx counters so each side keeps its own phase
	irda_tick_div #(.rst_count(irda_pkg::mir_rst_count)) mir_tx_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_tx_enable), .gate_i(mir_mode_i),
		.reload_i(mir_reload), .enable_o(mir_txbit_enable_o)
	);

	irda_tick_div #(.rst_count(irda_pkg::mir_rst_count)) mir_rx_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_rx_enable), .gate_i(mir_mode_i),
		.reload_i(mir_reload), .enable_o(mir_rxbit_enable_o)
	);

	irda_tick_div #(.rst_count(irda_pkg::fir8_reload)) fir_tx8_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_tx_enable), .gate_i(fir_mode_i),
		.reload_i(irda_pkg::fir8_reload), .enable_o(fir_tx8_enable_o)
	);

	irda_tick_div #(.rst_count(irda_pkg::fir4_reload)) fir_tx4_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_tx_enable), .gate_i(fir_mode_i),
		.reload_i(irda_pkg::fir4_reload), .enable_o(fir_tx4_enable_o)
	);

	irda_tick_div #(.rst_count(irda_pkg::fir8_reload)) fir_rx8_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_rx_enable), .gate_i(fir_mode_i),
		.reload_i(irda_pkg::fir8_reload), .enable_o(fir_rx8_enable_o)
	);

	irda_tick_div #(.rst_count(irda_pkg::fir4_reload)) fir_rx4_div_i (
		.clk(clk), .wb_rst_i(wb_rst_i), .strobe_i(fast_rx_enable), .gate_i(fir_mode_i),
		.reload_i(irda_pkg::fir4_reload), .enable_o(fir_rx4_enable_o)
	);

endmodule

// ==== irda_mode_ctrl.sv ====
module irda_mode_ctrl (
	input  logic                           clk,
	input  logic                           wb_rst_i,
	input  logic                           cfg_wr_i,
	input  irda_pkg::irda_mode_e           cfg_mode_i,
	input  logic [irda_pkg::cdr_width-1:0] cfg_cdr_i,
	input  logic                           fast_enable_i,
	output logic                           mir_mode_o,
	output logic                           mir_half_o,
	output logic                           fir_mode_o,
	output logic [irda_pkg::cdr_width-1:0] f_cdr_o,
	output logic                           en_reload_o,
	output logic                           mode_active_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_reload,
		st_settle,
		st_run
	} state_e;

	state_e               state;
	irda_pkg::irda_mode_e mode_q;
	logic [irda_pkg::cdr_width-1:0] cdr_q;

	// config latch, divisor starts at the reset rate
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			mode_q <= irda_pkg::mode_off;
			cdr_q <= irda_pkg::reset_cdr;
		end else if (cfg_wr_i) begin
			mode_q <= cfg_mode_i;
			cdr_q <= cfg_cdr_i;
		end
	end

	// a write in any state restarts the sequence
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state <= st_idle;
		end else if (cfg_wr_i) begin
			state <= st_reload;
		end else begin
			case (state)
				st_reload: begin
					if (mode_q == irda_pkg::mode_off)
						state <= st_idle;	// nothing to wait for
					else
						state <= st_settle;
				end
				st_settle: begin
					if (fast_enable_i)
						state <= st_run;	// first strobe at new rate
				end
				default: state <= state;	// idle and run hold
			endcase
		end
	end

	assign en_reload_o = (state == st_reload);
	assign mode_active_o = (state == st_run);
	assign f_cdr_o = cdr_q;

	// mode decode
	assign mir_mode_o = (mode_q == irda_pkg::mode_mir_full) || (mode_q == irda_pkg::mode_mir_half);
	assign mir_half_o = (mode_q == irda_pkg::mode_mir_half);
	assign fir_mode_o = (mode_q == irda_pkg::mode_fir);

endmodule

// ==== irda_tx_serializer.sv ====
module irda_tx_serializer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     wb_rst_i,
	input  logic     shift_i,
	input  logic     load_i,
	input  payload_t data_i,
	output logic     bit_o,
	output logic     ready_o
);

	localparam int nbits = $bits(payload_t);
	localparam int cnt_width = $clog2(nbits + 1);

	logic [nbits-1:0]     shreg;
	logic [cnt_width-1:0] bits_left;	// bits not yet on the line

	// control, a load is only taken while idle
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ready_o <= 1'b1;
			bit_o <= 1'b0;
			bits_left <= '0;
		end else if (ready_o) begin
			if (load_i) begin
				ready_o <= 1'b0;
				bits_left <= cnt_width'(nbits);
			end
		end else if (shift_i) begin
			if (bits_left != '0) begin
				bit_o <= shreg[0];	// LSB first
				bits_left <= bits_left - 1'b1;
			end else begin
				bit_o <= 1'b0;	// last bit period over
				ready_o <= 1'b1;
			end
		end
	end

	// payload shifter
	always_ff @(posedge clk) begin
		if (ready_o && load_i)
			shreg <= data_i;
		else if (!ready_o && shift_i)
			shreg <= shreg >> 1;
	end

endmodule

// ==== irda_fast_top.sv ====
module irda_fast_top (
	input  logic                           clk,
	input  logic                           wb_rst_i,
	input  logic                           cfg_wr_i,
	input  irda_pkg::irda_mode_e           cfg_mode_i,
	input  logic [irda_pkg::cdr_width-1:0] cfg_cdr_i,
	input  logic                           tx_select_i,
	input  logic                           loopback_enable_i,
	input  logic                           mir_load_i,
	input  irda_pkg::mir_byte_t            mir_data_i,
	input  logic                           fir_load_i,
	input  irda_pkg::fir_chip_t            fir_data_i,
	output logic                           mode_active_o,
	output logic                           fast_enable_o,
	output logic                           mir_txbit_enable_o,
	output logic                           mir_rxbit_enable_o,
	output logic                           fir_tx8_enable_o,
	output logic                           fir_tx4_enable_o,
	output logic                           fir_rx8_enable_o,
	output logic                           fir_rx4_enable_o,
	output logic                           mir_bit_o,
	output logic                           mir_ready_o,
	output logic                           fir_bit_o,
	output logic                           fir_ready_o
);

	logic                           mir_mode;
	logic                           mir_half;
	logic                           fir_mode;
	logic [irda_pkg::cdr_width-1:0] f_cdr;
	logic                           en_reload;

	irda_mode_ctrl irda_mode_ctrl_i (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.cfg_wr_i      (cfg_wr_i),
		.cfg_mode_i    (cfg_mode_i),
		.cfg_cdr_i     (cfg_cdr_i),
		.fast_enable_i (fast_enable_o),
		.mir_mode_o    (mir_mode),
		.mir_half_o    (mir_half),
		.fir_mode_o    (fir_mode),
		.f_cdr_o       (f_cdr),
		.en_reload_o   (en_reload),
		.mode_active_o (mode_active_o)
	);

	irda_fast_enable_gen irda_fast_enable_gen_i (
		.clk                (clk),
		.wb_rst_i           (wb_rst_i),
		.tx_select_i        (tx_select_i),
		.loopback_enable_i  (loopback_enable_i),
		.mir_mode_i         (mir_mode),
		.mir_half_i         (mir_half),
		.fir_mode_i         (fir_mode),
		.f_cdr_i            (f_cdr),
		.en_reload_i        (en_reload),
		.fast_enable_o      (fast_enable_o),
		.mir_txbit_enable_o (mir_txbit_enable_o),
		.mir_rxbit_enable_o (mir_rxbit_enable_o),
		.fir_tx8_enable_o   (fir_tx8_enable_o),
		.fir_tx4_enable_o   (fir_tx4_enable_o),
		.fir_rx8_enable_o   (fir_rx8_enable_o),
		.fir_rx4_enable_o   (fir_rx4_enable_o)
	);

	// MIR byte shifter, one bit per MIR bit time
	irda_tx_serializer #(.payload_t(irda_pkg::mir_byte_t)) mir_ser_i (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.shift_i  (mir_txbit_enable_o),
		.load_i   (mir_load_i),
		.data_i   (mir_data_i),
		.bit_o    (mir_bit_o),
		.ready_o  (mir_ready_o)
	);

	// FIR chip group shifter
	irda_tx_serializer #(.payload_t(irda_pkg::fir_chip_t)) fir_ser_i (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.shift_i  (fir_tx4_enable_o),
		.load_i   (fir_load_i),
		.data_i   (fir_data_i),
		.bit_o    (fir_bit_o),
		.ready_o  (fir_ready_o)
	);

endmodule

// ==== irda_fast_sva.sv ====
module irda_fast_sva (
	input logic       clk,
	input logic       wb_rst_i,
	input logic       tx_select_i,
	input logic       loopback_enable_i,
	input logic [5:0] enables_i,	// all six tick enables
	input logic [2:0] tx_enables_i,
	input logic       ready_i,
	input logic       load_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// a tick divider never pulses on two strobes in a row
	single_cycle_enable: assert property (
		@(posedge clk) disable iff (wb_rst_i) (enables_i & $past(enables_i)) == 6'b0
	) else $error("tick enable high for two cycles");

	// enables are registered, so the routing of the previous cycle applies
	tx_quiet_when_rx_only: assert property (
		@(posedge clk) disable iff (wb_rst_i)
		(!$past(tx_select_i) && !$past(loopback_enable_i)) |-> tx_enables_i == 3'b0
	) else $error("tx enable while only the receive side is selected");

	ready_falls_on_load: assert property (
		@(posedge clk) disable iff (wb_rst_i) $fell(ready_i) |-> $past(load_i)
	) else $error("ready dropped without a load");

endmodule

bind irda_fast_enable_gen irda_fast_sva enable_gen_sva_i (
	.clk               (clk),
	.wb_rst_i          (wb_rst_i),
	.tx_select_i       (tx_select_i),
	.loopback_enable_i (loopback_enable_i),
	.enables_i         ({mir_txbit_enable_o, mir_rxbit_enable_o, fir_tx8_enable_o,
		fir_tx4_enable_o, fir_rx8_enable_o, fir_rx4_enable_o}),
	.tx_enables_i      ({mir_txbit_enable_o, fir_tx8_enable_o, fir_tx4_enable_o}),
	.ready_i           (1'b1),
	.load_i            (1'b0)
);

// serializer copy only watches ready, the enable checks see constant zero
bind irda_tx_serializer irda_fast_sva serializer_sva_i (
	.clk               (clk),
	.wb_rst_i          (wb_rst_i),
	.tx_select_i       (1'b1),
	.loopback_enable_i (1'b0),
	.enables_i         (6'b0),
	.tx_enables_i      (3'b0),
	.ready_i           (ready_o),
	.load_i            (load_i)
);

// ==== tb_irda_fast_top.sv ====
module tb_irda_fast_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycle_limit = 2000;	// bound for every wait loop
	localparam logic [irda_pkg::cdr_width-1:0] cdr_div5 =
		irda_pkg::cdr_width'(5 * irda_pkg::mult);	// one strobe per 5 clocks
	localparam logic [irda_pkg::cdr_width-1:0] cdr_div3 =
		irda_pkg::cdr_width'(3 * irda_pkg::mult);	// one strobe per 3 clocks

	logic                           clk;
	logic                           wb_rst_i;
	logic                           cfg_wr_i;
	irda_pkg::irda_mode_e           cfg_mode_i;
	logic [irda_pkg::cdr_width-1:0] cfg_cdr_i;
	logic                           tx_select_i;
	logic                           loopback_enable_i;
	logic                           mir_load_i;
	irda_pkg::mir_byte_t            mir_data_i;
	logic                           fir_load_i;
	irda_pkg::fir_chip_t            fir_data_i;
	logic                           mode_active_o;
	logic                           fast_enable_o;
	logic                           mir_txbit_enable_o;
	logic                           mir_rxbit_enable_o;
	logic                           fir_tx8_enable_o;
	logic                           fir_tx4_enable_o;
	logic                           fir_rx8_enable_o;
	logic                           fir_rx4_enable_o;
	logic                           mir_bit_o;
	logic                           mir_ready_o;
	logic                           fir_bit_o;
	logic                           fir_ready_o;

	logic [5:0] enables;	// mir tx, mir rx, fir tx8, fir tx4, fir rx8, fir rx4
	int         pulses [6];	// indexed like enables
	int         errors;
	int         checks;
	int         tests;
	int         seed;

	irda_fast_top irda_fast_top_i (.*);

	assign enables = {mir_txbit_enable_o, mir_rxbit_enable_o, fir_tx8_enable_o,
		fir_tx4_enable_o, fir_rx8_enable_o, fir_rx4_enable_o};

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// all outputs are registered, so reading them here is safe
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, actual,
				expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		tests++;
		if (errors == errors_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errors_at_start);
	endtask

	// returns just after the reload edge
	task automatic write_config(input irda_pkg::irda_mode_e mode,
		input logic [irda_pkg::cdr_width-1:0] cdr);
		cfg_mode_i = mode;
		cfg_cdr_i = cdr;
		cfg_wr_i = 1'b1;
		next_cycle();
		cfg_wr_i = 1'b0;
		next_cycle();
	endtask

	task automatic wait_active();
		int n;
		n = 0;
		while (mode_active_o !== 1'b1 && n < cycle_limit) begin
			next_cycle();
			n++;
		end
		if (mode_active_o !== 1'b1) begin
			errors++;
			$display("Timeout: mode_active_o stayed low for %0d cycles", cycle_limit);
		end
	endtask

	task automatic wait_strobe(output int n);
		n = 0;
		while (fast_enable_o !== 1'b1 && n < cycle_limit) begin
			next_cycle();
			n++;
		end
		if (fast_enable_o !== 1'b1) begin
			errors++;
			$display("Timeout: no fast_enable_o strobe within %0d cycles", cycle_limit);
		end
	endtask

	task automatic wait_ready(input logic use_fir);
		int n;
		n = 0;
		while ((use_fir ? fir_ready_o : mir_ready_o) !== 1'b1 && n < cycle_limit) begin
			next_cycle();
			n++;
		end
		if ((use_fir ? fir_ready_o : mir_ready_o) !== 1'b1) begin
			errors++;
			$display("Timeout: serializer did not become ready within %0d cycles", cycle_limit);
		end
	endtask

	// counts the enable pulses that answer the next nstrobes fast strobes
	task automatic count_window(input int nstrobes);
		int   strobes;
		int   n;
		int   i;
		logic prev_fast;
		strobes = 0;
		n = 0;
		for (i = 0; i < 6; i++)
			pulses[i] = 0;
		prev_fast = fast_enable_o;
		while (strobes < nstrobes && n < cycle_limit) begin
			next_cycle();
			n++;
			if (prev_fast) begin	// enables show one cycle after their strobe
				strobes++;
				for (i = 0; i < 6; i++)
					pulses[i] += int'(enables[i]);
			end
			prev_fast = fast_enable_o;
		end
		if (strobes < nstrobes) begin
			errors++;
			$display("Timeout: only %0d of %0d fast strobes seen", strobes, nstrobes);
		end
	endtask

	task automatic check_counts(input int mtx, input int mrx, input int ftx8, input int ftx4,
		input int frx8, input int frx4);
		check_value("mir_txbit_enable_o pulses", pulses[5], mtx);
		check_value("mir_rxbit_enable_o pulses", pulses[4], mrx);
		check_value("fir_tx8_enable_o pulses", pulses[3], ftx8);
		check_value("fir_tx4_enable_o pulses", pulses[2], ftx4);
		check_value("fir_rx8_enable_o pulses", pulses[1], frx8);
		check_value("fir_rx4_enable_o pulses", pulses[0], frx4);
	endtask

	task automatic drive_load(input logic use_fir, input logic [7:0] data, input logic load);
		if (use_fir) begin
			fir_load_i = load;
			fir_data_i = data[3:0];
		end else begin
			mir_load_i = load;
			mir_data_i = data;
		end
	endtask

	// loads a payload and follows it bit by bit on the shift strobes
	task automatic send_payload(input logic use_fir, input logic [7:0] data, input int nbits);
		int   k;
		int   n;
		logic shift_seen;
		k = 0;
		n = 0;
		drive_load(use_fir, data, 1'b1);
		next_cycle();
		drive_load(use_fir, ~data, 1'b0);
		check_value("ready after load", 32'(use_fir ? fir_ready_o : mir_ready_o), 0);
		shift_seen = use_fir ? fir_tx4_enable_o : mir_txbit_enable_o;
		while (k <= nbits && n < cycle_limit) begin
			next_cycle();
			n++;
			drive_load(use_fir, ~data, 1'b0);
			if (shift_seen) begin
				k++;
				if (k <= nbits) begin
					check_value("serial bit", 32'(use_fir ? fir_bit_o : mir_bit_o),
						32'(data[k-1]));
					check_value("ready while sending", 32'(use_fir ? fir_ready_o : mir_ready_o), 0);
				end else begin
					check_value("ready after last bit", 32'(use_fir ? fir_ready_o : mir_ready_o), 1);
					check_value("idle bit", 32'(use_fir ? fir_bit_o : mir_bit_o), 0);
				end
				if (k == 1)
					drive_load(use_fir, ~data, 1'b1);	// busy, must be ignored
			end
			shift_seen = use_fir ? fir_tx4_enable_o : mir_txbit_enable_o;
		end
		if (k <= nbits) begin
			errors++;
			$display("Timeout: only %0d shift strobes seen while sending", k);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		int n;
		int busy;
		busy = 0;
		for (n = 0; n < cycles; n++) begin
			next_cycle();
			if (enables !== 6'b0 || mode_active_o !== 1'b0 || mir_ready_o !== 1'b1
				|| fir_ready_o !== 1'b1)
				busy++;
		end
		check_value("cycles with activity", busy, 0);
	endtask

	task automatic test_reset_state();
		int errors_at_start;
		errors_at_start = errors;
		expect_quiet(200);
		report_test("reset state", errors_at_start);
	endtask

	task automatic test_divider_rate();
		int errors_at_start;
		int n;
		int k;
		errors_at_start = errors;
		write_config(irda_pkg::mode_mir_full, cdr_div5);
		check_value("fast_enable_o after reload", 32'(fast_enable_o), 0);
		wait_strobe(n);
		check_value("cycles from reload to first strobe", n, 5);
		check_value("mode_active_o at first strobe", 32'(mode_active_o), 0);
		next_cycle();
		check_value("mode_active_o after first strobe", 32'(mode_active_o), 1);
		for (k = 0; k < 6; k++) begin
			wait_strobe(n);
			check_value("strobe period", n + 1, 5);
			next_cycle();
		end
		// divisor away from the reset rate
		write_config(irda_pkg::mode_mir_full, cdr_div3);
		wait_strobe(n);
		check_value("cycles from reload to first strobe at divisor 3", n, 3);
		next_cycle();
		wait_strobe(n);
		check_value("strobe period at divisor 3", n + 1, 3);
		report_test("divider rate", errors_at_start);
	endtask

	task automatic test_mir_ticks();
		int errors_at_start;
		errors_at_start = errors;
		write_config(irda_pkg::mode_mir_full, cdr_div5);
		wait_active();
		count_window(16);	// past the rate change
		count_window(80);
		check_counts(20, 0, 0, 0, 0, 0);
		write_config(irda_pkg::mode_mir_half, cdr_div5);
		wait_active();
		count_window(16);
		count_window(80);
		check_counts(10, 0, 0, 0, 0, 0);
		report_test("mir ticks", errors_at_start);
	endtask

	task automatic test_fir_ticks();
		int errors_at_start;
		errors_at_start = errors;
		write_config(irda_pkg::mode_fir, cdr_div5);
		wait_active();
		count_window(20);
		count_window(100);
		check_counts(0, 0, 20, 10, 0, 0);
		tx_select_i = 1'b0;	// receive side only
		count_window(20);
		count_window(100);
		check_counts(0, 0, 0, 0, 20, 10);
		loopback_enable_i = 1'b1;
		count_window(20);
		count_window(100);
		check_counts(0, 0, 20, 10, 20, 10);
		loopback_enable_i = 1'b0;
		tx_select_i = 1'b1;
		report_test("fir ticks", errors_at_start);
	endtask

	task automatic test_mir_serializer();
		int errors_at_start;
		errors_at_start = errors;
		write_config(irda_pkg::mode_mir_full, cdr_div5);
		wait_active();
		wait_ready(1'b0);
		send_payload(1'b0, 8'($random(seed)), 8);
		report_test("mir serializer", errors_at_start);
	endtask

	task automatic test_fir_serializer();
		int errors_at_start;
		errors_at_start = errors;
		write_config(irda_pkg::mode_fir, cdr_div5);
		wait_active();
		wait_ready(1'b1);
		send_payload(1'b1, 8'($random(seed)), 4);
		report_test("fir serializer", errors_at_start);
	endtask

	task automatic test_mode_off();
		int errors_at_start;
		errors_at_start = errors;
		write_config(irda_pkg::mode_off, cdr_div5);
		expect_quiet(200);
		report_test("mode off", errors_at_start);
	endtask

	initial begin
		seed = 50071;
		errors = 0;
		checks = 0;
		tests = 0;
		wb_rst_i = 1'b1;
		cfg_wr_i = 1'b0;
		cfg_mode_i = irda_pkg::mode_off;
		cfg_cdr_i = irda_pkg::reset_cdr;
		tx_select_i = 1'b1;
		loopback_enable_i = 1'b0;
		mir_load_i = 1'b0;
		mir_data_i = '0;
		fir_load_i = 1'b0;
		fir_data_i = '0;
		repeat (2) @(posedge clk);
		#2;
		wb_rst_i = 1'b0;

		test_reset_state();
		test_divider_rate();
		test_mir_ticks();
		test_fir_ticks();
		test_mir_serializer();
		test_fir_serializer();
		test_mode_off();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== build.f ====
irda_pkg.sv
irda_frac_div.sv
irda_tick_div.sv
irda_fast_enable_gen.sv
irda_mode_ctrl.sv
irda_tx_serializer.sv
irda_fast_top.sv
irda_fast_sva.sv
tb_irda_fast_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_irda_fast_top -f build.f -o tb_irda_fast_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_irda_fast_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST FAILED ***' "$log"; then
	echo "failure reported in $log"
	exit 1
fi

echo "simulation finished without failures"
exit 0
